// File: rtl/decode_params.svh
// decode stage widths, register count and bubble encoding shared by package and rtl
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// data path and instruction widths
`define XLEN        64
`define INSTR_W     32

// register file geometry
`define REG_IDX_W   5
`define NUM_REGS    32

// immediate fields as carried by the stage
`define IMM12_W     12
`define UIMM_W      20

// funct3 joined with the 7-bit major opcode
`define OP_TAG_W    10
// funct3 0 with the fence opcode, acts as a nop downstream
`define BUBBLE_OP_TAG 10'h00f

`endif

// File: rtl/decode_pkg.sv
// decode stage types: major opcode encoding and the structs passed between blocks
`include "decode_params.svh"

package decode_pkg;

    // rv64 major opcodes seen by the decoder
    typedef enum logic [6:0] {
        op_r      = 7'b0110011,
        op_r_w    = 7'b0111011,
        op_jalr   = 7'b1100111,
        op_load   = 7'b0000011,
        op_imm    = 7'b0010011,
        op_imm_w  = 7'b0011011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_fence  = 7'b0001111,
        op_system = 7'b1110011
    } major_op_e;

    // fields split out of one instruction
    typedef struct packed {
        logic [`REG_IDX_W-1:0] rs1;
        logic [`REG_IDX_W-1:0] rs2;
        logic [`REG_IDX_W-1:0] dest;
        logic [`IMM12_W-1:0]   imm12;
        logic [`UIMM_W-1:0]    uimm;
        logic [`OP_TAG_W-1:0]  op_tag;
    } dec_fields_t;

    // destinations still in flight further down the pipe
    typedef struct packed {
        logic [`REG_IDX_W-1:0] alu_dest;
        logic                  alu_is_store;
        logic [`REG_IDX_W-1:0] mem_dest;
        logic [`REG_IDX_W-1:0] wb_dest;
        logic                  mem_busy;
    } pipe_dests_t;

    // write-back port into the register file
    typedef struct packed {
        logic                  en;
        logic [`REG_IDX_W-1:0] idx;
        logic [`XLEN-1:0]      data;
    } wb_write_t;

    // what the stage hands to the alu stage
    typedef struct packed {
        logic [`REG_IDX_W-1:0] dest;
        logic [`REG_IDX_W-1:0] rs1;
        logic [`IMM12_W-1:0]   imm12;
        logic [`UIMM_W-1:0]    uimm;
        logic [`OP_TAG_W-1:0]  op_tag;
        logic [`XLEN-1:0]      pc;
        logic [`INSTR_W-1:0]   instr;
    } issue_t;

endpackage

// File: rtl/instr_field_decoder.sv
// instruction field decoder: splits a 32-bit instruction into indices, immediates and tag
`timescale 1ns/1ps
`include "decode_params.svh"

module instr_field_decoder import decode_pkg::*; (
    input  logic [`INSTR_W-1:0] instr,
    output dec_fields_t         fields
);

    major_op_e             major_op;
    logic [2:0]            funct3;
    logic [`REG_IDX_W-1:0] rs1_raw;
    logic [`REG_IDX_W-1:0] rs2_raw;
    logic [`REG_IDX_W-1:0] rd_raw;
    logic [`UIMM_W-1:0]    jal_offset;

    // raw slices, selected per class below
    assign major_op = major_op_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign rs1_raw  = instr[19:15];
    assign rs2_raw  = instr[24:20];
    assign rd_raw   = instr[11:7];

    // jal offset bits 20, 10:1, 11, 19:12 put back in order
    // low bit of the offset is implied zero
    assign jal_offset = {instr[31], instr[19:12], instr[20], instr[30:21]};

    always_comb begin
        // imm12 passes through for every class
        fields.imm12  = instr[31:20];
        // defaults match an unknown opcode
        fields.rs1    = '0;
        fields.rs2    = '0;
        fields.dest   = '0;
        fields.uimm   = '0;
        fields.op_tag = '0;

        case (major_op)
            // register-register, both sources and a destination
            op_r,
            op_r_w: begin
                fields.rs1    = rs1_raw;
                fields.rs2    = rs2_raw;
                fields.dest   = rd_raw;
                fields.op_tag = {funct3, instr[6:0]};
            end

            // one source, immediate in imm12
            op_jalr,
            op_load,
            op_imm,
            op_imm_w: begin
                fields.rs1    = rs1_raw;
                fields.dest   = rd_raw;
                fields.op_tag = {funct3, instr[6:0]};
            end

            // csr and environment calls
            // csr number rides in imm12
            op_system: begin
                fields.rs1    = rs1_raw;
                fields.dest   = rd_raw;
                fields.op_tag = {funct3, instr[6:0]};
            end

            // stores and branches read two sources, write nothing
            // bits 11:7 hold immediate bits here, not a register
            op_store,
            op_branch: begin
                fields.rs1    = rs1_raw;
                fields.rs2    = rs2_raw;
                fields.op_tag = {funct3, instr[6:0]};
            end

            // upper immediates, no sources
            op_lui,
            op_auipc: begin
                fields.dest   = rd_raw;
                fields.uimm   = instr[31:12];
                fields.op_tag = {funct3, instr[6:0]};
            end

            // jump and link
            op_jal: begin
                fields.dest   = rd_raw;
                fields.uimm   = jal_offset;
                fields.op_tag = {funct3, instr[6:0]};
            end

            // fence reads and writes no registers
            // pred and succ bits stay in imm12
            op_fence: begin
                fields.op_tag = {funct3, instr[6:0]};
            end

            default: begin
                // unknown opcode, leave defaults
                fields.op_tag = '0;
            end
        endcase
    end

endmodule

// File: rtl/hazard_detector.sv
// hazard detector: stalls decode on a source matching an in-flight destination or busy memory
`timescale 1ns/1ps
`include "decode_params.svh"

module hazard_detector import decode_pkg::*; (
    input  dec_fields_t fields,
    input  pipe_dests_t pipe_dests,
    output logic        need_stall
);

    logic alu_hit;
    logic mem_hit;
    logic wb_hit;

    // destination 0 is never a real producer
    function automatic logic dest_hits(
        input logic [`REG_IDX_W-1:0] dest,
        input logic [`REG_IDX_W-1:0] src_a,
        input logic [`REG_IDX_W-1:0] src_b
    );
        return (dest != '0) && ((dest == src_a) || (dest == src_b));
    endfunction

    // a store in alu has no result to wait for
    assign alu_hit = dest_hits(pipe_dests.alu_dest, fields.rs1, fields.rs2)
                     && !pipe_dests.alu_is_store;

    // memory and write-back results not yet in the register file
    assign mem_hit = dest_hits(pipe_dests.mem_dest, fields.rs1, fields.rs2);
    assign wb_hit  = dest_hits(pipe_dests.wb_dest, fields.rs1, fields.rs2);

    // no forwarding, so any hit waits it out
    // busy memory backs up the whole pipe
    assign need_stall = alu_hit || mem_hit || wb_hit || pipe_dests.mem_busy;

endmodule

// File: rtl/register_file.sv
// register file: 32 by 64-bit integer registers, one write port, two registered read ports
`timescale 1ns/1ps
`include "decode_params.svh"

module register_file import decode_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  wb_write_t             wb_write,
    input  logic                  rd_en,
    input  logic [`REG_IDX_W-1:0] rd_idx_a,
    input  logic [`REG_IDX_W-1:0] rd_idx_b,
    output logic [`XLEN-1:0]      rd_data_a,
    output logic [`XLEN-1:0]      rd_data_b
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    // write port
    // x0 is never written, so it stays zero after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write.en && (wb_write.idx != '0)) begin
            regs[wb_write.idx] <= wb_write.data;
        end
    end

    // read ports sample the array before this edge's write
    // same-cycle read of the written index sees the old value
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_data_a <= '0;
            rd_data_b <= '0;
        end else if (rd_en) begin
            rd_data_a <= regs[rd_idx_a];
            rd_data_b <= regs[rd_idx_b];
        end
        // rd_en low holds the operands across a stall
    end

endmodule

// File: rtl/decode_stage.sv
// decode stage top: field split, hazard check, operand read and issue register with bubbles
`timescale 1ns/1ps
`include "decode_params.svh"

module decode_stage import decode_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic [`INSTR_W-1:0] instr,
    input  logic [`XLEN-1:0]    pc,
    input  wb_write_t           wb_write,
    input  pipe_dests_t         pipe_dests,
    input  logic                flush,
    output issue_t              issue,
    output logic [`XLEN-1:0]    rd_data_a,
    output logic [`XLEN-1:0]    rd_data_b,
    output logic                stall
);

    dec_fields_t fields;
    logic        need_stall;
    logic        flush_q;
    logic        bubble;
    issue_t      issue_d;

    // combinational split of the incoming instruction
    instr_field_decoder u_field_decoder (
        .instr  (instr),
        .fields (fields)
    );

    // source vs in-flight destination compare
    hazard_detector u_hazard_detector (
        .fields     (fields),
        .pipe_dests (pipe_dests),
        .need_stall (need_stall)
    );

    // operands land together with the issue register
    // write-back keeps writing during a stall
    register_file u_register_file (
        .clk       (clk),
        .reset     (reset),
        .wb_write  (wb_write),
        .rd_en     (!need_stall),
        .rd_idx_a  (fields.rs1),
        .rd_idx_b  (fields.rs2),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    // flush kills this slot and the one after it
    // the second covers the wrong-path fetch already in flight
    assign bubble = need_stall || flush || flush_q;

    always_comb begin
        // fields always follow the current inputs
        issue_d.pc     = pc;
        issue_d.instr  = instr;
        issue_d.rs1    = fields.rs1;
        issue_d.imm12  = fields.imm12;

        // bubble writes no register and issues as a fence nop
        issue_d.dest   = bubble ? '0 : fields.dest;
        issue_d.op_tag = bubble ? `BUBBLE_OP_TAG : fields.op_tag;

        // upper immediate frozen while stalled
        issue_d.uimm   = need_stall ? issue.uimm : fields.uimm;
    end

    // issue register, registered stall and flush memory
    always_ff @(posedge clk) begin
        if (reset) begin
            issue   <= '0;
            stall   <= 1'b0;
            flush_q <= 1'b0;
        end else begin
            issue   <= issue_d;
            stall   <= need_stall;
            flush_q <= flush;
        end
    end

endmodule

// File: dv/decode_stage_assertions.sv
// decode stage assertions: bubbles after stall and flush, x0 read stays zero
`timescale 1ns/1ps
`include "decode_params.svh"

module decode_stage_assertions import decode_pkg::*; (
    input logic             clk,
    input logic             reset,
    input logic             stall,
    input logic             flush,
    input logic             need_stall,
    input dec_fields_t      fields,
    input wb_write_t        wb_write,
    input issue_t           issue,
    input logic [`XLEN-1:0] rd_data_a
);

    logic issued_bubble;

    // dest 0 with the fence nop tag
    assign issued_bubble = (issue.dest == '0) && (issue.op_tag == `BUBBLE_OP_TAG);

    // registered stall and bubble leave on the same edge
    stall_gives_bubble: assert property (
        @(posedge clk) disable iff (reset) stall |-> issued_bubble
    ) else $error("stall without a bubble in the issue register");

    // flushed slot plus the one behind it
    flush_two_bubbles: assert property (
        @(posedge clk) disable iff (reset) flush |=> issued_bubble ##1 issued_bubble
    ) else $error("flush did not give two bubble cycles");

    // x0 read the cycle after a write to index 0
    x0_reads_zero: assert property (
        @(posedge clk) disable iff (reset)
        (wb_write.en && (wb_write.idx == '0)) ##1 ((fields.rs1 == '0) && !need_stall)
            |=> (rd_data_a == '0)
    ) else $error("x0 read nonzero after a write to index 0");

endmodule

bind decode_stage decode_stage_assertions u_assertions (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .flush      (flush),
    .need_stall (need_stall),
    .fields     (fields),
    .wb_write   (wb_write),
    .issue      (issue),
    .rd_data_a  (rd_data_a)
);

// File: dv/decode_stage_tb.sv
// decode stage testbench: directed tests of field split, operand read, stalls and flush
`timescale 1ns/1ps
`include "decode_params.svh"

module decode_stage_tb import decode_pkg::*; ();

    logic                clk;
    logic                reset;
    logic [`INSTR_W-1:0] instr;
    logic [`XLEN-1:0]    pc;
    wb_write_t           wb_write;
    pipe_dests_t         pipe_dests;
    logic                flush;
    issue_t              issue;
    logic [`XLEN-1:0]    rd_data_a;
    logic [`XLEN-1:0]    rd_data_b;
    logic                stall;

    integer seed;
    int     errors;
    int     checks;
    int     tests;
    int     timeouts;
    // expected register contents, x0 never written
    logic [`XLEN-1:0] reg_model [`NUM_REGS];

    decode_stage DUT (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .pc         (pc),
        .wb_write   (wb_write),
        .pipe_dests (pipe_dests),
        .flush      (flush),
        .issue      (issue),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .stall      (stall)
    );

    // 20 ns period
    initial clk = 1'b0;
    always #10 clk = ~clk;

    // instruction formats
    function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
            input logic [6:0] op);
        return {funct7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    // store layout, reused for branches
    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] op);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
            input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    // jal scatters offset bits 20, 10:1, 11, 19:12
    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // imm12 is bits 31:20, tag is funct3 with the opcode
    function automatic issue_t expected_issue(input logic [4:0] dest, input logic [4:0] rs1,
            input logic [19:0] uimm, input logic [31:0] ins, input logic [63:0] pc_v);
        issue_t e;
        e.dest   = dest;
        e.rs1    = rs1;
        e.imm12  = ins[31:20];
        e.uimm   = uimm;
        e.op_tag = {ins[14:12], ins[6:0]};
        e.pc     = pc_v;
        e.instr  = ins;
        return e;
    endfunction

    function automatic issue_t make_bubble(input issue_t e);
        issue_t b;
        b        = e;
        b.dest   = '0;
        b.op_tag = `BUBBLE_OP_TAG;
        return b;
    endfunction

    // n edges, then 1 ns for sampling and driving
    task automatic advance(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic check_issue(input issue_t got, input issue_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_data(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
            input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    // bounded wait for the hazard to drain
    task automatic wait_stall_clear(input int limit, input string what);
        int waited;
        waited = 0;
        while (stall !== 1'b0 && waited < limit) begin
            advance(1);
            waited++;
        end
        if (stall !== 1'b0) begin
            errors++;
            timeouts++;
            $display("timeout at %0t ns: stall still high after %0d cycles in %s",
                     $time, limit, what);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        $display("test %s done, %0d errors", name, errors - errs_before);
    endtask

    task automatic test_reset;
        int errs_before;
        errs_before = errors;
        check_bit(stall, 1'b0, "stall after reset");
        check_issue(issue, '0, "issue after reset");
        // read x1 and x31
        instr = r_type(7'h00, 5'd31, 5'd1, 3'b000, 5'd2, op_r);
        pc    = 64'h1000;
        advance(1);
        check_data(rd_data_a, '0, "x1 after reset");
        check_data(rd_data_b, '0, "x31 after reset");
        end_test("reset", errs_before);
    endtask

    task automatic test_write_read;
        int               errs_before;
        logic [`XLEN-1:0] data;
        errs_before = errors;
        for (int k = 5; k <= 8; k++) begin
            data          = {$random(seed), $random(seed)};
            wb_write.en   = 1'b1;
            wb_write.idx  = 5'(k);
            wb_write.data = data;
            reg_model[k]  = data;
            advance(1);
        end
        // x0 write while x0 is being read
        instr         = r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd0, op_r);
        wb_write.idx  = 5'd0;
        wb_write.data = {$random(seed), $random(seed)};
        advance(1);
        check_data(rd_data_a, '0, "x0 during write");
        // x0 read right behind the write
        wb_write.en = 1'b0;
        instr = r_type(7'h00, 5'd5, 5'd0, 3'b000, 5'd9, op_r);
        advance(1);
        check_data(rd_data_a, '0, "x0 after write");
        check_data(rd_data_b, reg_model[5], "x5 read with x0");
        instr = r_type(7'h00, 5'd6, 5'd5, 3'b000, 5'd9, op_r);
        advance(1);
        check_data(rd_data_a, reg_model[5], "x5 read");
        check_data(rd_data_b, reg_model[6], "x6 read");
        instr = r_type(7'h00, 5'd8, 5'd7, 3'b000, 5'd9, op_r);
        advance(1);
        check_data(rd_data_a, reg_model[7], "x7 read");
        check_data(rd_data_b, reg_model[8], "x8 read");
        end_test("write_read", errs_before);
    endtask

    task automatic decode_one(input logic [31:0] ins, input logic [4:0] dest,
            input logic [4:0] rs1, input logic [19:0] uimm, input string what);
        logic [63:0] pc_v;
        pc_v  = pc + 64'd4;
        instr = ins;
        pc    = pc_v;
        advance(1);
        check_issue(issue, expected_issue(dest, rs1, uimm, ins, pc_v), what);
    endtask

    task automatic test_fields;
        int          errs_before;
        logic [20:0] jal_off;
        errs_before = errors;
        jal_off     = 21'h0f2468;
        decode_one(r_type(7'h20, 5'd9, 5'd10, 3'b000, 5'd11, op_r), 5'd11, 5'd10, '0, "r");
        decode_one(i_type(12'h7f8, 5'd2, 3'b011, 5'd12, op_load), 5'd12, 5'd2, '0, "load");
        decode_one(i_type(12'hfff, 5'd3, 3'b000, 5'd13, op_imm), 5'd13, 5'd3, '0, "imm");
        // no destination for store and branch
        decode_one(s_type(12'h123, 5'd4, 5'd5, 3'b011, op_store), 5'd0, 5'd5, '0, "store");
        decode_one(s_type(12'h0a5, 5'd6, 5'd7, 3'b001, op_branch), 5'd0, 5'd7, '0, "branch");
        decode_one(u_type(20'habcde, 5'd14, op_lui), 5'd14, 5'd0, 20'habcde, "lui");
        // offset bit 0 is not carried
        decode_one(j_type(jal_off, 5'd1), 5'd1, 5'd0, jal_off[20:1], "jal");
        decode_one(i_type(12'h305, 5'd8, 3'b001, 5'd15, op_system), 5'd15, 5'd8, '0, "system");
        end_test("fields", errs_before);
    endtask

    task automatic stall_case(input pipe_dests_t dests, input string what);
        logic [31:0] ins;
        issue_t      exp;
        // prime the operands with x5 and x6
        pipe_dests = '0;
        instr      = r_type(7'h00, 5'd6, 5'd5, 3'b000, 5'd9, op_r);
        pc         = 64'h2000;
        advance(1);
        ins        = r_type(7'h00, 5'd8, 5'd7, 3'b111, 5'd10, op_r);
        instr      = ins;
        pc         = 64'h2004;
        pipe_dests = dests;
        exp        = expected_issue(5'd10, 5'd7, '0, ins, 64'h2004);
        // two stalled cycles, operands held
        for (int c = 0; c < 2; c++) begin
            advance(1);
            check_bit(stall, 1'b1, {what, " stall"});
            check_issue(issue, make_bubble(exp), {what, " bubble"});
            check_data(rd_data_a, reg_model[5], {what, " held a"});
            check_data(rd_data_b, reg_model[6], {what, " held b"});
        end
        pipe_dests = '0;
        wait_stall_clear(4, what);
        check_issue(issue, exp, {what, " reissue"});
        check_data(rd_data_a, reg_model[7], {what, " new a"});
        check_data(rd_data_b, reg_model[8], {what, " new b"});
    endtask

    task automatic test_stalls;
        int          errs_before;
        pipe_dests_t d;
        logic [31:0] ins;
        errs_before = errors;
        d = '0;
        d.alu_dest = 5'd7;
        stall_case(d, "alu rs1");
        d = '0;
        d.mem_dest = 5'd8;
        stall_case(d, "mem rs2");
        d = '0;
        d.wb_dest = 5'd7;
        stall_case(d, "wb rs1");
        d = '0;
        d.mem_busy = 1'b1;
        stall_case(d, "mem busy");
        // store in alu produces nothing to wait for
        d = '0;
        d.alu_dest     = 5'd7;
        d.alu_is_store = 1'b1;
        ins        = r_type(7'h00, 5'd8, 5'd7, 3'b111, 5'd10, op_r);
        instr      = ins;
        pc         = 64'h2100;
        pipe_dests = d;
        advance(1);
        pipe_dests = '0;
        check_bit(stall, 1'b0, "alu store no stall");
        check_issue(issue, expected_issue(5'd10, 5'd7, '0, ins, 64'h2100), "alu store issue");
        check_data(rd_data_a, reg_model[7], "alu store a");
        end_test("stalls", errs_before);
    endtask

    task automatic test_flush;
        int          errs_before;
        logic [31:0] ins_a;
        logic [31:0] ins_b;
        logic [31:0] ins_c;
        errs_before = errors;
        ins_a = r_type(7'h00, 5'd6, 5'd5, 3'b000, 5'd9, op_r);
        ins_b = u_type(20'h12345, 5'd3, op_lui);
        ins_c = r_type(7'h00, 5'd8, 5'd7, 3'b000, 5'd11, op_r);
        flush = 1'b1;
        instr = ins_a;
        pc    = 64'h3000;
        advance(1);
        flush = 1'b0;
        check_issue(issue, make_bubble(expected_issue(5'd9, 5'd5, '0, ins_a, 64'h3000)),
                    "flush slot");
        instr = ins_b;
        pc    = 64'h3004;
        advance(1);
        // uimm still follows, no stall here
        check_issue(issue, make_bubble(expected_issue(5'd3, 5'd0, 20'h12345, ins_b, 64'h3004)),
                    "slot after flush");
        instr = ins_c;
        pc    = 64'h3008;
        advance(1);
        check_issue(issue, expected_issue(5'd11, 5'd7, '0, ins_c, 64'h3008), "third slot");
        check_bit(stall, 1'b0, "no stall on flush");
        end_test("flush", errs_before);
    endtask

    initial begin
        seed       = 32'hd7e3;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        timeouts   = 0;
        reset      = 1'b1;
        instr      = '0;
        pc         = '0;
        wb_write   = '0;
        pipe_dests = '0;
        flush      = 1'b0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            reg_model[i] = '0;
        end
        advance(16);
        reset = 1'b0;
        test_reset;
        test_write_read;
        test_fields;
        test_stalls;
        test_flush;
        $display("summary: %0d tests, %0d checks, %0d errors, %0d timeouts",
                 tests, checks, errors, timeouts);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+rtl
rtl/decode_pkg.sv
rtl/instr_field_decoder.sv
rtl/hazard_detector.sv
rtl/register_file.sv
rtl/decode_stage.sv
dv/decode_stage_assertions.sv
dv/decode_stage_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := decode_stage_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
